//--- verilog/bexkat_config.svh
`ifndef BEXKAT_CONFIG_SVH
`define BEXKAT_CONFIG_SVH

`define BEXKAT_XLEN     32
`define BEXKAT_NREGS    32
`define BEXKAT_RESET_PC 32'h0000_0000

`define BEXKAT_MODE_REG    3'h0
`define BEXKAT_MODE_REGIND 3'h1
`define BEXKAT_MODE_IMM    3'h2

// register mode
`define BEXKAT_OP_NOP 8'h00
`define BEXKAT_OP_CMP 8'h02
`define BEXKAT_OP_INC 8'h03
`define BEXKAT_OP_DEC 8'h04
`define BEXKAT_OP_MOV 8'h07
`define BEXKAT_OP_COM 8'h08
`define BEXKAT_OP_NEG 8'h09
`define BEXKAT_OP_AND 8'h20
`define BEXKAT_OP_OR  8'h21
`define BEXKAT_OP_ADD 8'h22
`define BEXKAT_OP_SUB 8'h23
`define BEXKAT_OP_XOR 8'h24

// immediate mode branches run from 8'h00 up to brn
`define BEXKAT_OP_BRN  8'h0b
`define BEXKAT_OP_LDIS 8'h0c
`define BEXKAT_OP_LDIU 8'h0d

// register-indirect mode
`define BEXKAT_OP_STL 8'h00
`define BEXKAT_OP_LDL 8'h01
`define BEXKAT_OP_LDA 8'h0a
`define BEXKAT_OP_JMP 8'h0b

`endif

//--- verilog/bexkat_pkg.sv
`include "bexkat_config.svh"

package bexkat_pkg;

  typedef logic [`BEXKAT_XLEN-1:0] word_t;
  typedef logic [$clog2(`BEXKAT_NREGS)-1:0] reg_addr_t;

  // rc overlays the top five bits of disp
  typedef struct packed {
    logic [2:0]  mode;
    logic [7:0]  op;
    reg_addr_t   ra;
    reg_addr_t   rb;
    logic [10:0] disp;
  } insn_reg_t;

  typedef struct packed {
    logic [2:0]  mode;
    logic [7:0]  op;
    reg_addr_t   ra;
    logic [15:0] imm;
  } insn_imm_t;

  typedef union packed {
    insn_reg_t r;
    insn_imm_t i;
  } insn_t;

  typedef struct packed {
    insn_t insn;
    word_t addr;
  } fetch_item_t;

  typedef struct packed {
    word_t pc;
  } redirect_t;

  typedef struct packed {
    logic  write;
    word_t addr;
    word_t wdata;
  } mem_req_t;

  // low nibble of the register-mode alu opcodes
  typedef enum logic [3:0] {
    ALU_AND = 4'h0,
    ALU_OR  = 4'h1,
    ALU_ADD = 4'h2,
    ALU_SUB = 4'h3,
    ALU_XOR = 4'h4
  } alu_func_t;

  typedef struct packed {
    logic c;
    logic n;
    logic v;
    logic z;
  } flags_t;

endpackage

//--- verilog/alu.sv
`include "bexkat_config.svh"

module alu (
  input  bexkat_pkg::word_t     in1,
  input  bexkat_pkg::word_t     in2,
  input  bexkat_pkg::alu_func_t func,
  output bexkat_pkg::word_t     result,
  output bexkat_pkg::flags_t    flags
);
  import bexkat_pkg::*;

  localparam int MSB = `BEXKAT_XLEN - 1;

  logic [`BEXKAT_XLEN:0] diff;  // top bit is the borrow

  assign diff = {1'b0, in1} - {1'b0, in2};

  always_comb begin
    case (func)
      ALU_AND: result = in1 & in2;
      ALU_OR:  result = in1 | in2;
      ALU_ADD: result = in1 + in2;
      ALU_SUB: result = diff[MSB:0];
      ALU_XOR: result = in1 ^ in2;
      default: result = '0;
    endcase
  end

  // flags always describe in1 - in2
  assign flags = '{
    c: diff[`BEXKAT_XLEN],
    n: diff[MSB],
    v: (in1[MSB] ^ in2[MSB]) & (in1[MSB] ^ diff[MSB]),
    z: (diff[MSB:0] == '0)
  };

endmodule

//--- verilog/register_file.sv
`include "bexkat_config.svh"

module register_file (
  input  logic                  csi_clk,
  input  logic                  rsi_reset_n,
  input  bexkat_pkg::reg_addr_t read_addr1,
  input  bexkat_pkg::reg_addr_t read_addr2,
  output bexkat_pkg::word_t     read_data1,
  output bexkat_pkg::word_t     read_data2,
  input  logic                  write_en,
  input  bexkat_pkg::reg_addr_t write_addr,
  input  bexkat_pkg::word_t     write_data
);
  import bexkat_pkg::*;

  word_t regs [`BEXKAT_NREGS];

  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      for (int i = 0; i < `BEXKAT_NREGS; i++)
        regs[i] <= '0;
    end else if (write_en) begin
      regs[write_addr] <= write_data;
    end
  end

  assign read_data1 = regs[read_addr1];
  assign read_data2 = regs[read_addr2];

endmodule

//--- verilog/fetch_unit.sv
`include "bexkat_config.svh"

module fetch_unit (
  input  logic                    csi_clk,
  input  logic                    rsi_reset_n,
  input  bexkat_pkg::redirect_t   redirect,
  input  logic                    redirect_valid,
  input  logic                    halted,
  output bexkat_pkg::fetch_item_t item,
  output logic                    item_valid,
  input  logic                    item_ready,
  output bexkat_pkg::mem_req_t    bus_req,
  output logic                    bus_valid,
  input  logic                    bus_done,
  input  bexkat_pkg::word_t       bus_rdata
);
  import bexkat_pkg::*;

  word_t pc;    // address of the next word to fetch
  logic  stale; // in-flight fetch was overtaken by a redirect
  logic  take;
  logic  issue;

  assign take  = bus_done && !stale && !redirect_valid;
  assign issue = !bus_valid && !halted && (!item_valid || item_ready);

  // pc only moves on a kept fetch, so it is the request address
  assign bus_req = '{write: 1'b0, addr: pc, wdata: '0};

  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      pc         <= `BEXKAT_RESET_PC;
      item_valid <= 1'b0;
      bus_valid  <= 1'b0;
      stale      <= 1'b0;
    end else begin
      if (item_valid && item_ready)
        item_valid <= 1'b0;
      if (take) begin
        item_valid <= 1'b1;
        pc         <= pc + 'd4;
      end
      if (bus_done) begin
        bus_valid <= 1'b0;
        stale     <= 1'b0;
      end else if (issue) begin
        bus_valid <= 1'b1;
      end
      if (redirect_valid) begin
        pc         <= redirect.pc;
        item_valid <= 1'b0;               // flush wrong-path item
        stale      <= bus_valid && !bus_done;
      end
    end
  end

  always_ff @(posedge csi_clk) begin
    if (take) begin
      item.insn <= bus_rdata;
      item.addr <= pc;
    end
  end

endmodule

//--- verilog/control_unit.sv
`include "bexkat_config.svh"

module control_unit (
  input  logic                    csi_clk,
  input  logic                    rsi_reset_n,
  input  bexkat_pkg::fetch_item_t item,
  input  logic                    item_valid,
  output logic                    item_ready,
  output bexkat_pkg::redirect_t   redirect,
  output logic                    redirect_valid,
  output bexkat_pkg::mem_req_t    mem_req,
  output logic                    mem_valid,
  input  logic                    mem_ready,
  input  logic                    load_valid,
  input  logic                    done_valid,
  input  bexkat_pkg::word_t       load_data,
  output logic                    halted
);
  import bexkat_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_EXEC, S_MEM, S_HALT} state_t;

  state_t      state;
  fetch_item_t cur;  // instruction in execute
  flags_t      flags;
  flags_t      alu_flags;
  alu_func_t   func;
  word_t       rdata1;
  word_t       rdata2;
  word_t       alu_in2;
  word_t       alu_result;
  word_t       wdata;
  word_t       simm;
  word_t       disp;
  word_t       target;
  reg_addr_t   ra;
  reg_addr_t   rb;
  reg_addr_t   rc;
  reg_addr_t   read_addr1;
  reg_addr_t   read_addr2;
  logic [2:0]  mode;
  logic [7:0]  op;
  logic        alu_rr;
  logic        wr;
  logic        mem_op;
  logic        jump;
  logic        taken;
  logic        set_flags;
  logic        illegal;

  assign mode   = cur.insn.r.mode;
  assign op     = cur.insn.r.op;
  assign ra     = cur.insn.r.ra;
  assign rb     = cur.insn.r.rb;
  assign rc     = cur.insn.r.disp[10:6];
  assign simm   = {{(`BEXKAT_XLEN-16){cur.insn.i.imm[15]}}, cur.insn.i.imm};
  assign disp   = {{(`BEXKAT_XLEN-11){cur.insn.r.disp[10]}}, cur.insn.r.disp};
  assign target = cur.addr + 'd4 + simm;
  assign alu_rr = (mode == `BEXKAT_MODE_REG) && (op[7:4] == 4'h2);

  // regind reads base on port 1 and store data on port 2
  assign read_addr1 = (alu_rr || mode == `BEXKAT_MODE_REGIND) ? rb : ra;
  assign read_addr2 = alu_rr ? rc : (mode == `BEXKAT_MODE_REGIND) ? ra : rb;

  always_comb begin
    case (op[3:0])
      4'h0:    taken = 1'b1;                              // bra
      4'h1:    taken = flags.z;                           // beq
      4'h2:    taken = !flags.z;                          // bne
      4'h3:    taken = !(flags.z || flags.c);             // bgtu
      4'h4:    taken = !(flags.z || (flags.n ^ flags.v)); // bgt
      4'h5:    taken = !(flags.n ^ flags.v);              // bge
      4'h6:    taken = flags.z || (flags.n ^ flags.v);    // ble
      4'h7:    taken = flags.n ^ flags.v;                 // blt
      4'h8:    taken = !flags.c;                          // bgeu
      4'h9:    taken = flags.c;                           // bltu
      4'ha:    taken = flags.c || flags.z;                // bleu
      default: taken = 1'b0;                              // brn
    endcase
  end

  always_comb begin
    func      = ALU_ADD;
    alu_in2   = rdata2;
    wdata     = alu_result;
    wr        = 1'b0;
    mem_op    = 1'b0;
    jump      = 1'b0;
    set_flags = 1'b0;
    illegal   = 1'b0;
    case (mode)
      `BEXKAT_MODE_REG: begin
        case (op)
          `BEXKAT_OP_NOP: begin
          end
          `BEXKAT_OP_CMP: begin
            func      = ALU_SUB;
            set_flags = 1'b1;
          end
          `BEXKAT_OP_INC: begin
            alu_in2 = 'd1;
            wr      = 1'b1;
          end
          `BEXKAT_OP_DEC: begin
            func    = ALU_SUB;
            alu_in2 = 'd1;
            wr      = 1'b1;
          end
          `BEXKAT_OP_MOV: begin
            wdata = rdata2;
            wr    = 1'b1;
          end
          `BEXKAT_OP_COM: begin
            wdata = ~rdata2;
            wr    = 1'b1;
          end
          `BEXKAT_OP_NEG: begin
            wdata = -rdata2;
            wr    = 1'b1;
          end
          `BEXKAT_OP_AND, `BEXKAT_OP_OR, `BEXKAT_OP_ADD, `BEXKAT_OP_SUB, `BEXKAT_OP_XOR: begin
            func = alu_func_t'(op[3:0]);
            wr   = 1'b1;
          end
          default: illegal = 1'b1;
        endcase
      end
      `BEXKAT_MODE_IMM: begin
        if (op == `BEXKAT_OP_LDIS) begin
          wdata = simm;
          wr    = 1'b1;
        end else if (op == `BEXKAT_OP_LDIU) begin
          wdata = {{(`BEXKAT_XLEN-16){1'b0}}, cur.insn.i.imm};
          wr    = 1'b1;
        end else if (op > `BEXKAT_OP_BRN) begin
          illegal = 1'b1;
        end else begin
          jump = taken;
        end
      end
      `BEXKAT_MODE_REGIND: begin
        alu_in2 = disp;  // rb + displacement
        case (op)
          `BEXKAT_OP_STL, `BEXKAT_OP_LDL: mem_op = 1'b1;
          `BEXKAT_OP_LDA: wr = 1'b1;
          `BEXKAT_OP_JMP: jump = 1'b1;
          default: illegal = 1'b1;
        endcase
      end
      default: illegal = 1'b1;
    endcase
  end

  assign item_ready     = (state == S_IDLE);
  assign halted         = (state == S_HALT);
  assign redirect_valid = (state == S_EXEC) && jump;
  assign redirect       = '{pc: (mode == `BEXKAT_MODE_IMM) ? target : alu_result};
  assign mem_valid      = (state == S_EXEC) && mem_op;
  assign mem_req        = '{write: (op == `BEXKAT_OP_STL), addr: alu_result, wdata: rdata2};

  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      state <= S_IDLE;
      flags <= '0;
    end else begin
      case (state)
        S_IDLE: if (item_valid) state <= S_EXEC;
        S_EXEC: begin
          if (illegal)
            state <= S_HALT;
          else if (!mem_op)
            state <= S_IDLE;
          else if (mem_ready)
            state <= S_MEM;
          if (set_flags)
            flags <= alu_flags;
        end
        S_MEM: if (load_valid || done_valid) state <= S_IDLE;
        default: state <= S_HALT;  // stuck until reset
      endcase
    end
  end

  always_ff @(posedge csi_clk) begin
    if (item_valid && item_ready)
      cur <= item;
  end

  register_file i_regs (
    .csi_clk,
    .rsi_reset_n,
    .read_addr1,
    .read_addr2,
    .read_data1 (rdata1),
    .read_data2 (rdata2),
    .write_en   ((state == S_EXEC && wr) || (state == S_MEM && load_valid)),
    .write_addr (ra),
    .write_data ((state == S_MEM) ? load_data : wdata)
  );

  alu i_alu (
    .in1    (rdata1),
    .in2    (alu_in2),
    .func,
    .result (alu_result),
    .flags  (alu_flags)
  );

endmodule

//--- verilog/load_store_unit.sv
module load_store_unit (
  input  logic                 csi_clk,
  input  logic                 rsi_reset_n,
  input  bexkat_pkg::mem_req_t req,
  input  logic                 req_valid,
  output logic                 req_ready,
  output logic                 load_valid,
  output logic                 done_valid,
  output bexkat_pkg::word_t    load_data,
  output bexkat_pkg::mem_req_t bus_req,
  output logic                 bus_valid,
  input  logic                 bus_done,
  input  bexkat_pkg::word_t    bus_rdata
);

  logic accept;

  assign req_ready = !bus_valid;  // one request at a time
  assign accept    = req_valid && req_ready;

  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      bus_valid  <= 1'b0;
      load_valid <= 1'b0;
      done_valid <= 1'b0;
    end else begin
      load_valid <= bus_done && !bus_req.write;
      done_valid <= bus_done && bus_req.write;
      if (bus_done)
        bus_valid <= 1'b0;
      else if (accept)
        bus_valid <= 1'b1;
    end
  end

  always_ff @(posedge csi_clk) begin
    if (accept)
      bus_req <= req;
    if (bus_done && !bus_req.write)
      load_data <= bus_rdata;
  end

endmodule

//--- verilog/bus_arbiter.sv
module bus_arbiter (
  input  logic                 csi_clk,
  input  logic                 rsi_reset_n,
  input  bexkat_pkg::mem_req_t fetch_req,
  input  logic                 fetch_valid,
  input  bexkat_pkg::mem_req_t lsu_req,
  input  logic                 lsu_valid,
  output logic                 fetch_done,
  output logic                 lsu_done,
  output bexkat_pkg::word_t    rdata,
  input  logic                 avm_m0_waitrequest,
  input  bexkat_pkg::word_t    avm_m0_readdata,
  output bexkat_pkg::word_t    avm_m0_address,
  output bexkat_pkg::word_t    avm_m0_writedata,
  output logic                 avm_m0_read,
  output logic                 avm_m0_write
);
  import bexkat_pkg::*;

  mem_req_t sel;
  logic     busy;
  logic     owner_lsu;  // who holds the bus
  logic     lsu_go;
  logic     fetch_go;
  logic     finish;

  // a unit's valid is still up during its done pulse
  assign lsu_go   = lsu_valid && !lsu_done;
  assign fetch_go = fetch_valid && !fetch_done && !lsu_go;
  assign sel      = lsu_go ? lsu_req : fetch_req;
  assign busy     = avm_m0_read || avm_m0_write;
  assign finish   = busy && !avm_m0_waitrequest;

  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      owner_lsu        <= 1'b0;
      avm_m0_read      <= 1'b0;
      avm_m0_write     <= 1'b0;
      avm_m0_address   <= '0;
      avm_m0_writedata <= '0;
      fetch_done       <= 1'b0;
      lsu_done         <= 1'b0;
    end else begin
      fetch_done <= finish && !owner_lsu;
      lsu_done   <= finish && owner_lsu;
      if (finish) begin
        avm_m0_read  <= 1'b0;
        avm_m0_write <= 1'b0;
      end else if (!busy && (lsu_go || fetch_go)) begin
        owner_lsu        <= lsu_go;
        avm_m0_read      <= !sel.write;
        avm_m0_write     <= sel.write;
        avm_m0_address   <= sel.addr;
        avm_m0_writedata <= sel.wdata;
      end
    end
  end

  always_ff @(posedge csi_clk) begin
    if (finish && avm_m0_read)
      rdata <= avm_m0_readdata;
  end

endmodule

//--- verilog/bexkat_core.sv
module bexkat_core (
  input  logic              csi_clk,
  input  logic              rsi_reset_n,
  input  logic              avm_m0_waitrequest,
  input  bexkat_pkg::word_t avm_m0_readdata,
  output bexkat_pkg::word_t avm_m0_address,
  output bexkat_pkg::word_t avm_m0_writedata,
  output logic              avm_m0_read,
  output logic              avm_m0_write,
  output logic [3:0]        avm_m0_byteenable,
  output logic              halted
);
  import bexkat_pkg::*;

  fetch_item_t item;
  logic        item_valid;
  logic        item_ready;
  redirect_t   redirect;
  logic        redirect_valid;

  mem_req_t    ctl_req;
  logic        ctl_valid;
  logic        ctl_ready;
  logic        load_valid;
  logic        done_valid;
  word_t       load_data;

  mem_req_t    fetch_req;
  logic        fetch_valid;
  logic        fetch_done;
  mem_req_t    lsu_req;
  logic        lsu_valid;
  logic        lsu_done;
  word_t       rdata;

  assign avm_m0_byteenable = 4'hf; // word accesses only

  fetch_unit i_fetch (
    .csi_clk,
    .rsi_reset_n,
    .redirect,
    .redirect_valid,
    .halted,
    .item,
    .item_valid,
    .item_ready,
    .bus_req   (fetch_req),
    .bus_valid (fetch_valid),
    .bus_done  (fetch_done),
    .bus_rdata (rdata)
  );

  control_unit i_control (
    .csi_clk,
    .rsi_reset_n,
    .item,
    .item_valid,
    .item_ready,
    .redirect,
    .redirect_valid,
    .mem_req   (ctl_req),
    .mem_valid (ctl_valid),
    .mem_ready (ctl_ready),
    .load_valid,
    .done_valid,
    .load_data,
    .halted
  );

  load_store_unit i_lsu (
    .csi_clk,
    .rsi_reset_n,
    .req       (ctl_req),
    .req_valid (ctl_valid),
    .req_ready (ctl_ready),
    .load_valid,
    .done_valid,
    .load_data,
    .bus_req   (lsu_req),
    .bus_valid (lsu_valid),
    .bus_done  (lsu_done),
    .bus_rdata (rdata)
  );

  bus_arbiter i_arbiter (
    .csi_clk,
    .rsi_reset_n,
    .fetch_req,
    .fetch_valid,
    .lsu_req,
    .lsu_valid,
    .fetch_done,
    .lsu_done,
    .rdata,
    .avm_m0_waitrequest,
    .avm_m0_readdata,
    .avm_m0_address,
    .avm_m0_writedata,
    .avm_m0_read,
    .avm_m0_write
  );

endmodule

//--- bench/tb_memory.sv
module tb_memory #(
  parameter int WORDS = 4096,
  parameter int SEED  = 50
) (
  input  logic              csi_clk,
  input  logic              rsi_reset_n,
  input  bexkat_pkg::word_t address,
  input  bexkat_pkg::word_t writedata,
  input  logic              read,
  input  logic              write,
  output logic              waitrequest,
  output bexkat_pkg::word_t readdata
);
  timeunit 1ns;
  timeprecision 100ps;
  import bexkat_pkg::*;

  word_t mem [WORDS];  // loaded by the testbench
  int    seed;
  int    idx;

  initial begin
    seed        = SEED;
    waitrequest = 1'b1;
    readdata    = '0;
  end

  always @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      waitrequest <= 1'b1;
      readdata    <= '0;
    end else begin
      idx = int'(address[$clog2(WORDS)+1:2]);
      if ((read || write) && !waitrequest) begin
        if (write)
          mem[idx] <= writedata;
        waitrequest <= #1 1'b1;  // next transaction starts waiting
      end else if ((read || write) && (($random(seed) & 3) == 0)) begin
        readdata    <= #1 mem[idx];
        waitrequest <= #1 1'b0;
      end
    end
  end

endmodule

//--- bench/bexkat_props.sv
module bexkat_props (
  input logic              csi_clk,
  input logic              rsi_reset_n,
  input logic              avm_m0_read,
  input logic              avm_m0_write,
  input logic              avm_m0_waitrequest,
  input bexkat_pkg::word_t avm_m0_address,
  input bexkat_pkg::word_t avm_m0_writedata,
  input logic              halted
);
  timeunit 1ns;
  timeprecision 100ps;

  a_rd_wr_excl: assert property (@(posedge csi_clk) !(avm_m0_read && avm_m0_write))
    else $error("read and write high together");

  a_hold: assert property (@(posedge csi_clk) disable iff (!rsi_reset_n)
    (avm_m0_read || avm_m0_write) && avm_m0_waitrequest |=>
      $stable(avm_m0_address) && $stable(avm_m0_writedata)
      && $stable(avm_m0_read) && $stable(avm_m0_write))
    else $error("bus request changed while waitrequest was high");

  a_reset_idle: assert property (@(posedge csi_clk) !rsi_reset_n |-> !avm_m0_read && !avm_m0_write)
    else $error("bus active during reset");

  a_halt_sticky: assert property (@(posedge csi_clk) disable iff (!rsi_reset_n)
    halted |=> halted)
    else $error("halted dropped before reset");

endmodule

bind bexkat_core bexkat_props i_props (.*);

//--- bench/tb_bexkat.sv
`include "bexkat_config.svh"

module tb_bexkat;
  timeunit 1ns;
  timeprecision 100ps;
  import bexkat_pkg::*;

  localparam int MEM_WORDS = 4096;

  logic       csi_clk;
  logic       rsi_reset_n;
  logic       waitrequest;
  word_t      readdata;
  word_t      address;
  word_t      writedata;
  logic       read;
  logic       write;
  logic [3:0] byteenable;
  logic       halted;

  word_t      image [MEM_WORDS];  // program plus fill, later the model's memory
  word_t      m_regs [`BEXKAT_NREGS];
  flags_t     m_flags;
  word_t      m_pc;
  logic       m_halted;
  mem_req_t   exp_q [$];
  mem_req_t   got_wr;
  word_t      gen_pc;
  int         seed;
  int         cycles;
  int         limit;
  int         prog_len;
  int         steps;

  bexkat_core i_dut (
    .csi_clk, .rsi_reset_n,
    .avm_m0_waitrequest (waitrequest),
    .avm_m0_readdata    (readdata),
    .avm_m0_address     (address),
    .avm_m0_writedata   (writedata),
    .avm_m0_read        (read),
    .avm_m0_write       (write),
    .avm_m0_byteenable  (byteenable),
    .halted
  );

  tb_memory #(.WORDS(MEM_WORDS), .SEED(50)) i_mem (
    .csi_clk, .rsi_reset_n, .address, .writedata, .read, .write, .waitrequest, .readdata
  );

  always #4 csi_clk = ~csi_clk;

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_write(string name, mem_req_t got, mem_req_t exp);
    if (got !== exp)
      abort_run($sformatf("** Error at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_addr(string name, word_t got, word_t exp);
    if (got !== exp)
      abort_run($sformatf("** Error at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_halt(string name, logic got, logic exp);
    if (got !== exp)
      abort_run($sformatf("** Error at %0t: %s got %b expected %b", $time, name, got, exp));
  endtask

  task automatic check_byteenable(string name, logic [3:0] got, logic [3:0] exp);
    if (got !== exp)
      abort_run($sformatf("** Error at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  function automatic int rnd(int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  function automatic word_t fill_word(int idx);
    word_t a;
    a = word_t'(idx) << 2;
    return (a * 32'h9e37_79b9) ^ 32'ha5a5_0f0f;  // every address bit matters
  endfunction

  function automatic word_t enc_r(logic [2:0] mode, logic [7:0] op, reg_addr_t ra,
                                  reg_addr_t rb, logic [10:0] disp);
    insn_t w;
    w.r = '{mode: mode, op: op, ra: ra, rb: rb, disp: disp};
    return w;
  endfunction

  function automatic word_t enc_i(logic [7:0] op, reg_addr_t ra, logic [15:0] imm);
    insn_t w;
    w.i = '{mode: `BEXKAT_MODE_IMM, op: op, ra: ra, imm: imm};
    return w;
  endfunction

  function automatic logic branch_taken(logic [3:0] cond, flags_t f);
    case (cond)
      4'h0:    return 1'b1;                   // bra
      4'h1:    return f.z;                    // beq
      4'h2:    return !f.z;                   // bne
      4'h3:    return !f.c && !f.z;           // bgtu
      4'h4:    return !f.z && (f.n == f.v);   // bgt
      4'h5:    return f.n == f.v;             // bge
      4'h6:    return f.z || (f.n != f.v);    // ble
      4'h7:    return f.n != f.v;             // blt
      4'h8:    return !f.c;                   // bgeu
      4'h9:    return f.c;                    // bltu
      4'ha:    return f.c || f.z;             // bleu
      default: return 1'b0;                   // brn
    endcase
  endfunction

  task automatic emit(word_t w);
    image[gen_pc[13:2]] = w;
    gen_pc += 4;
  endtask

  task automatic build_program();
    logic [7:0] ops [12];
    reg_addr_t  r1;
    reg_addr_t  r2;
    ops = '{`BEXKAT_OP_NOP, `BEXKAT_OP_CMP, `BEXKAT_OP_INC, `BEXKAT_OP_DEC,
            `BEXKAT_OP_MOV, `BEXKAT_OP_COM, `BEXKAT_OP_NEG, `BEXKAT_OP_AND,
            `BEXKAT_OP_OR, `BEXKAT_OP_ADD, `BEXKAT_OP_SUB, `BEXKAT_OP_XOR};
    for (int i = 0; i < MEM_WORDS; i++)
      image[i] = fill_word(i);
    gen_pc = `BEXKAT_RESET_PC;
    emit(enc_i(`BEXKAT_OP_LDIU, 5'd31, 16'h2000));  // r31 is the data base
    for (int r = 1; r < 30; r++)
      emit(enc_i(r[0] ? `BEXKAT_OP_LDIS : `BEXKAT_OP_LDIU, reg_addr_t'(r), 16'(rnd(65536))));
    for (int i = 0; i < 40; i++)
      emit(enc_r(`BEXKAT_MODE_REG, ops[rnd(12)], reg_addr_t'(1 + rnd(29)),
                 reg_addr_t'(rnd(30)), {5'(rnd(30)), 6'h0}));
    for (int r = 0; r < 32; r++)
      emit(enc_r(`BEXKAT_MODE_REGIND, `BEXKAT_OP_STL, reg_addr_t'(r), 5'd31, 11'(4 * r)));
    for (int b = 0; b < 12; b++) begin
      r1 = reg_addr_t'(1 + rnd(29));
      r2 = (b % 3 == 0) ? r1 : reg_addr_t'(1 + rnd(29));
      emit(enc_r(`BEXKAT_MODE_REG, `BEXKAT_OP_CMP, r1, r2, 11'h0));
      emit(enc_i(8'(b), 5'd0, 16'd8));                // taken skips to the second marker
      emit(enc_i(`BEXKAT_OP_LDIU, 5'd30, 16'haaaa));
      emit(enc_i(8'h00, 5'd0, 16'd4));
      emit(enc_i(`BEXKAT_OP_LDIU, 5'd30, 16'hbbbb));
      emit(enc_r(`BEXKAT_MODE_REGIND, `BEXKAT_OP_STL, 5'd30, 5'd31, 11'(256 + 4 * b)));
    end
    emit(enc_r(`BEXKAT_MODE_REGIND, `BEXKAT_OP_STL, 5'd5, 5'd31, 11'h200));
    emit(enc_r(`BEXKAT_MODE_REGIND, `BEXKAT_OP_LDL, 5'd6, 5'd31, 11'h200));
    emit(enc_r(`BEXKAT_MODE_REGIND, `BEXKAT_OP_LDL, 5'd7, 5'd31, 11'h300)); // unwritten word
    emit(enc_r(`BEXKAT_MODE_REGIND, `BEXKAT_OP_LDA, 5'd8, 5'd31, 11'h7f0)); // negative disp
    emit(enc_i(`BEXKAT_OP_LDIU, 5'd9, 16'(gen_pc + 12)));
    emit(enc_r(`BEXKAT_MODE_REGIND, `BEXKAT_OP_JMP, 5'd0, 5'd9, 11'h0));
    emit(enc_r(`BEXKAT_MODE_REGIND, `BEXKAT_OP_STL, 5'd1, 5'd31, 11'h3f0)); // jumped over
    for (int r = 6; r < 9; r++)
      emit(enc_r(`BEXKAT_MODE_REGIND, `BEXKAT_OP_STL, reg_addr_t'(r), 5'd31, 11'(r * 4 + 512)));
    emit(32'hffff_ffff);                               // illegal mode halts
    emit(enc_r(`BEXKAT_MODE_REGIND, `BEXKAT_OP_STL, 5'd1, 5'd31, 11'h3fc));
    prog_len = int'(gen_pc >> 2);
  endtask

  function automatic void ref_step();
    insn_t        w;
    word_t        a;
    word_t        b;
    word_t        c;
    word_t        simm;
    word_t        addr;
    word_t        next;
    word_t        d;
    mem_req_t     st;
    w    = image[m_pc[13:2]];
    next = m_pc + 4;
    a    = m_regs[w.r.ra];
    b    = m_regs[w.r.rb];
    c    = m_regs[w.r.disp[10:6]];
    simm = {{16{w.i.imm[15]}}, w.i.imm};
    addr = b + {{21{w.r.disp[10]}}, w.r.disp};
    case (w.r.mode)
      `BEXKAT_MODE_REG:
        case (w.r.op)
          `BEXKAT_OP_NOP: ;
          `BEXKAT_OP_CMP: begin
            d         = a - b;
            m_flags.c = a < b;                                // unsigned borrow
            m_flags.n = d[31];
            m_flags.z = a == b;
            m_flags.v = ($signed(a) < $signed(b)) != d[31];   // true sign differs from result
          end
          `BEXKAT_OP_INC: m_regs[w.r.ra] = a + 1;
          `BEXKAT_OP_DEC: m_regs[w.r.ra] = a - 1;
          `BEXKAT_OP_MOV: m_regs[w.r.ra] = b;
          `BEXKAT_OP_COM: m_regs[w.r.ra] = ~b;
          `BEXKAT_OP_NEG: m_regs[w.r.ra] = 32'h0 - b;
          `BEXKAT_OP_AND: m_regs[w.r.ra] = b & c;
          `BEXKAT_OP_OR:  m_regs[w.r.ra] = b | c;
          `BEXKAT_OP_ADD: m_regs[w.r.ra] = b + c;
          `BEXKAT_OP_SUB: m_regs[w.r.ra] = b - c;
          `BEXKAT_OP_XOR: m_regs[w.r.ra] = b ^ c;
          default: m_halted = 1'b1;
        endcase
      `BEXKAT_MODE_IMM:
        if (w.i.op == `BEXKAT_OP_LDIS)
          m_regs[w.i.ra] = simm;
        else if (w.i.op == `BEXKAT_OP_LDIU)
          m_regs[w.i.ra] = {16'h0, w.i.imm};
        else if (w.i.op > `BEXKAT_OP_BRN)
          m_halted = 1'b1;
        else if (branch_taken(w.i.op[3:0], m_flags))
          next = m_pc + 4 + simm;
      `BEXKAT_MODE_REGIND:
        case (w.r.op)
          `BEXKAT_OP_STL: begin
            st = '{write: 1'b1, addr: addr, wdata: a};
            exp_q.push_back(st);
            image[addr[13:2]] = a;
          end
          `BEXKAT_OP_LDL: m_regs[w.r.ra] = image[addr[13:2]];
          `BEXKAT_OP_LDA: m_regs[w.r.ra] = addr;
          `BEXKAT_OP_JMP: next = addr;
          default: m_halted = 1'b1;
        endcase
      default: m_halted = 1'b1;
    endcase
    m_pc = next;
  endfunction

  // compare process on completed bus transactions
  always @(negedge csi_clk) begin
    if (rsi_reset_n && !waitrequest) begin
      if (read || write)
        check_byteenable("avm_m0_byteenable", byteenable, 4'hf);
      if (write) begin
        got_wr = '{write: write, addr: address, wdata: writedata};
        if (exp_q.size() == 0)
          abort_run($sformatf("unexpected write to %h at %0t", address, $time));
        else
          check_write("avm_m0_write transaction", got_wr, exp_q.pop_front());
      end
      if (read) begin
        check_addr("avm_m0_address[1:0]", address & 32'h3, 32'h0);
        if (address >= MEM_WORDS * 4)
          abort_run($sformatf("read outside memory at address %h", address));
      end
    end
  end

  always @(posedge csi_clk) begin
    cycles++;
    if (cycles > limit)
      abort_run($sformatf("timeout after %0d cycles without reaching the halt", cycles));
  end

  initial begin
    seed        = 50;
    cycles      = 0;
    csi_clk     = 1'b0;
    rsi_reset_n = 1'b0;
    build_program();
    for (int i = 0; i < MEM_WORDS; i++)
      i_mem.mem[i] = image[i];
    for (int r = 0; r < `BEXKAT_NREGS; r++)
      m_regs[r] = '0;
    m_flags  = '0;
    m_pc     = `BEXKAT_RESET_PC;
    m_halted = 1'b0;
    steps    = 0;
    while (!m_halted && steps < 10000) begin
      ref_step();
      steps++;
    end
    if (!m_halted)
      abort_run("reference model never reached the illegal opcode");
    limit = prog_len * 40;
    repeat (10) @(posedge csi_clk);
    #1 rsi_reset_n = 1'b1;
    check_halt("halted", halted, 1'b0);
    while (!halted)
      @(posedge csi_clk);
    repeat (20) @(posedge csi_clk);  // room for a stray write
    check_halt("halted", halted, 1'b1);
    if (exp_q.size() != 0) begin
      abort_run($sformatf("%0d expected writes never appeared on the bus", exp_q.size()));
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule

//--- verilog.f
+incdir+verilog
verilog/bexkat_pkg.sv
verilog/alu.sv
verilog/register_file.sv
verilog/fetch_unit.sv
verilog/control_unit.sv
verilog/load_store_unit.sv
verilog/bus_arbiter.sv
verilog/bexkat_core.sv
bench/tb_memory.sv
bench/bexkat_props.sv
bench/tb_bexkat.sv

//--- run.sh
#!/bin/sh
# build and run the bexkat core testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
  -f verilog.f --top-module tb_bexkat -o tb_bexkat &&
./obj_dir/tb_bexkat | tee /dev/stderr | grep "All tests passed" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
